// ==== Bender.yml ====
package:
  name: bmd_endpoint

sources:
  - include_dirs:
      - .
    files:
      - bmd_pkg.sv
      - bmd_rx_engine.sv
      - bmd_tx_engine.sv
      - bmd_reg_file.sv
      - bmd_endpoint.sv
      - target: test
        files:
          - tb_bmd_endpoint.sv

// ==== bmd_endpoint.sv ====
/* Bus-master endpoint top. Ties the RX engine, TX engine and register
   file to the inbound and outbound TLP streams. */
`default_nettype none
`include "bmd_params.svh"

module bmd_endpoint (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [`BMD_DW_W-1:0]  rx_data_i,
    input  wire                  rx_sof_i,
    input  wire                  rx_eof_i,
    input  wire                  rx_valid_i,
    output logic                 rx_ready_o,
    output logic [`BMD_DW_W-1:0] tx_data_o,
    output logic                 tx_sof_o,
    output logic                 tx_eof_o,
    output logic                 tx_valid_o,
    input  wire                  tx_ready_i,
    input  wire [15:0]           cfg_completer_id_i,
    input  wire                  cfg_bus_mstr_enable_i
);
    import bmd_pkg::*;

    logic                  wr_en;
    logic [`BMD_REG_AW-1:0] wr_idx;
    logic [`BMD_DW_W-1:0]  wr_data;
    logic [`BMD_REG_AW-1:0] rd_idx;
    logic [`BMD_DW_W-1:0]  rd_data;
    logic                  compl_req;
    logic                  compl_ack;
    tlp_dw1_u              req_dw1;
    logic [`BMD_REG_AW-1:0] req_idx;
    logic [6:0]            req_lo_addr;
    logic                  init_rst;
    logic                  dma_start;
    logic                  dma_done;
    logic [`BMD_DW_W-1:0]  dma_addr;
    logic [`BMD_DW_W-1:0]  dma_len;
    logic [`BMD_DW_W-1:0]  dma_count;
    logic [`BMD_DW_W-1:0]  dma_pattern;

    bmd_rx_engine rx0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_data_i     (rx_data_i),
        .rx_sof_i      (rx_sof_i),
        .rx_eof_i      (rx_eof_i),
        .rx_valid_i    (rx_valid_i),
        .rx_ready_o    (rx_ready_o),
        .init_rst_i    (init_rst),
        .wr_en_o       (wr_en),
        .wr_idx_o      (wr_idx),
        .wr_data_o     (wr_data),
        .compl_req_o   (compl_req),
        .compl_ack_i   (compl_ack),
        .req_dw1_o     (req_dw1),
        .req_idx_o     (req_idx),
        .req_lo_addr_o (req_lo_addr)
    );

    bmd_tx_engine tx0 (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .tx_data_o             (tx_data_o),
        .tx_sof_o              (tx_sof_o),
        .tx_eof_o              (tx_eof_o),
        .tx_valid_o            (tx_valid_o),
        .tx_ready_i            (tx_ready_i),
        .cfg_completer_id_i    (cfg_completer_id_i),
        .cfg_bus_mstr_enable_i (cfg_bus_mstr_enable_i),
        .init_rst_i            (init_rst),
        .compl_req_i           (compl_req),
        .compl_ack_o           (compl_ack),
        .req_dw1_i             (req_dw1),
        .req_idx_i             (req_idx),
        .req_lo_addr_i         (req_lo_addr),
        .rd_idx_o              (rd_idx),
        .rd_data_i             (rd_data),
        .dma_start_i           (dma_start),
        .dma_addr_i            (dma_addr),
        .dma_len_i             (dma_len),
        .dma_count_i           (dma_count),
        .dma_pattern_i         (dma_pattern),
        .dma_done_o            (dma_done)
    );

    bmd_reg_file regs0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en_i       (wr_en),
        .wr_idx_i      (wr_idx),
        .wr_data_i     (wr_data),
        .rd_idx_i      (rd_idx),
        .rd_data_o     (rd_data),
        .init_rst_o    (init_rst),
        .dma_start_o   (dma_start),
        .dma_addr_o    (dma_addr),
        .dma_len_o     (dma_len),
        .dma_count_o   (dma_count),
        .dma_pattern_o (dma_pattern),
        .dma_done_i    (dma_done)
    );

endmodule

`default_nettype wire

// ==== bmd_params.svh ====
/* Widths, register map, TLP format/type codes and DMA limits of the
   bus-master endpoint. Included by every module that uses them. */
`ifndef BMD_PARAMS_SVH
`define BMD_PARAMS_SVH

`define BMD_DW_W              32
`define BMD_REG_AW            3

// --------------------------------------------------
// Register map, one DW per index
// --------------------------------------------------
`define BMD_REG_CTRL          3'd0
`define BMD_REG_DMA_ADDR      3'd1
`define BMD_REG_DMA_LEN       3'd2
`define BMD_REG_DMA_COUNT     3'd3
`define BMD_REG_DMA_PATTERN   3'd4
`define BMD_REG_STATUS        3'd5

`define BMD_CTRL_INIT_RST_BIT 0
`define BMD_CTRL_START_BIT    16

// --------------------------------------------------
// TLP format/type and DMA limits
// --------------------------------------------------
`define BMD_FMT_MWR           7'h40   // 3DW header, with data
`define BMD_FMT_MRD           7'h00   // 3DW header, no data
`define BMD_FMT_CPLD          7'h4A
`define BMD_MAX_DMA_LEN       32      // DW per write TLP

`endif

// ==== bmd_pkg.sv ====
/* Header-word types shared by the RX and TX engines.
   Modules import it inside their body where the types are needed. */
`default_nettype none

package bmd_pkg;

    // Header DW0, common to requests and completions
    typedef struct packed {
        logic       rsvd_hi;
        logic [6:0] fmt_type;
        logic       rsvd_mid;
        logic [2:0] tc;
        logic [9:0] rsvd_lo;    // TD, EP, attributes, AT
        logic [9:0] length;     // In DW
    } tlp_dw0_t;

    // Header DW1 as seen in a memory request
    typedef struct packed {
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
    } tlp_req_dw1_t;

    // Header DW1 as seen in a completion
    typedef struct packed {
        logic [15:0] completer_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_count;
    } tlp_cpl_dw1_t;

    typedef union packed {
        tlp_req_dw1_t req;
        tlp_cpl_dw1_t cpl;
    } tlp_dw1_u;

endpackage

`default_nettype wire

// ==== bmd_reg_file.sv ====
/* Device registers. Holds the DMA setup and a sticky done flag, and turns
   control register writes into init reset and DMA start pulses. */
`default_nettype none
`include "bmd_params.svh"

module bmd_reg_file (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wr_en_i,
    input  wire [`BMD_REG_AW-1:0]   wr_idx_i,
    input  wire [`BMD_DW_W-1:0]     wr_data_i,
    input  wire [`BMD_REG_AW-1:0]   rd_idx_i,
    output logic [`BMD_DW_W-1:0]    rd_data_o,
    output logic                    init_rst_o,
    output logic                    dma_start_o,
    output logic [`BMD_DW_W-1:0]    dma_addr_o,
    output logic [`BMD_DW_W-1:0]    dma_len_o,
    output logic [`BMD_DW_W-1:0]    dma_count_o,
    output logic [`BMD_DW_W-1:0]    dma_pattern_o,
    input  wire                     dma_done_i
);

    logic ctrl_wr;
    logic done_q;

    // Control bits act only on the write cycle
    assign ctrl_wr     = wr_en_i && (wr_idx_i == `BMD_REG_CTRL);
    assign init_rst_o  = ctrl_wr && wr_data_i[`BMD_CTRL_INIT_RST_BIT];
    assign dma_start_o = ctrl_wr && wr_data_i[`BMD_CTRL_START_BIT];

    // --------------------------------------------------
    // DMA setup registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dma_addr_o    <= '0;
            dma_len_o     <= '0;
            dma_count_o   <= '0;
            dma_pattern_o <= '0;
        end else if (wr_en_i) begin
            case (wr_idx_i)
                `BMD_REG_DMA_ADDR:    dma_addr_o    <= wr_data_i;
                `BMD_REG_DMA_LEN:     dma_len_o     <= wr_data_i;
                `BMD_REG_DMA_COUNT:   dma_count_o   <= wr_data_i;
                `BMD_REG_DMA_PATTERN: dma_pattern_o <= wr_data_i;
                default:              ;   // Control and status handled elsewhere
            endcase
        end
    end

    // Sticky done flag cleared only by init reset
    always_ff @(posedge clk) begin
        if (!rst_n)
            done_q <= 1'b0;
        else if (init_rst_o)
            done_q <= 1'b0;
        else if (dma_done_i)
            done_q <= 1'b1;
    end

    // --------------------------------------------------
    // Read mux
    // --------------------------------------------------
    always_comb begin
        case (rd_idx_i)
            `BMD_REG_DMA_ADDR:    rd_data_o = dma_addr_o;
            `BMD_REG_DMA_LEN:     rd_data_o = dma_len_o;
            `BMD_REG_DMA_COUNT:   rd_data_o = dma_count_o;
            `BMD_REG_DMA_PATTERN: rd_data_o = dma_pattern_o;
            `BMD_REG_STATUS:      rd_data_o = {{(`BMD_DW_W-1){1'b0}}, done_q};
            default:              rd_data_o = '0;   // Self-clearing control and unmapped 6 and 7
        endcase
    end

endmodule

`default_nettype wire

// ==== bmd_rx_engine.sv ====
/* Parses inbound request TLPs. One-DW writes become register write pulses,
   one-DW reads are handed to the TX engine by a four-phase req/ack. */
`default_nettype none
`include "bmd_params.svh"

module bmd_rx_engine (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`BMD_DW_W-1:0]     rx_data_i,
    input  wire                     rx_sof_i,
    input  wire                     rx_eof_i,
    input  wire                     rx_valid_i,
    output logic                    rx_ready_o,
    input  wire                     init_rst_i,
    output logic                    wr_en_o,
    output logic [`BMD_REG_AW-1:0]  wr_idx_o,
    output logic [`BMD_DW_W-1:0]    wr_data_o,
    output logic                    compl_req_o,
    input  wire                     compl_ack_i,
    output bmd_pkg::tlp_dw1_u       req_dw1_o,
    output logic [`BMD_REG_AW-1:0]  req_idx_o,
    output logic [6:0]              req_lo_addr_o
);
    import bmd_pkg::*;

    tlp_dw0_t   dw0_q;
    logic [1:0] beat_cnt;   // Index of the next beat, saturates at 3
    logic       in_tlp;
    logic       beat;
    logic       len_one;
    logic       is_mwr1;
    logic       is_mrd1;

    assign beat       = rx_valid_i && rx_ready_o;
    assign rx_ready_o = !compl_req_o;    // One read in flight at a time
    assign wr_idx_o   = req_idx_o;

    assign len_one = (dw0_q.length == 10'd1);
    assign is_mwr1 = len_one && (dw0_q.fmt_type == `BMD_FMT_MWR);
    assign is_mrd1 = len_one && (dw0_q.fmt_type == `BMD_FMT_MRD);

    // --------------------------------------------------
    // Beat counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= 2'd0;
            in_tlp   <= 1'b0;
        end else if (beat && (rx_sof_i || in_tlp)) begin
            in_tlp   <= !rx_eof_i;
            if (rx_sof_i)
                beat_cnt <= 2'd1;
            else if (beat_cnt != 2'd3)
                beat_cnt <= beat_cnt + 2'd1;
        end else if (init_rst_i) begin
            beat_cnt <= 2'd0;    // Abandon any partial TLP
            in_tlp   <= 1'b0;
        end
    end

    // Header capture
    always_ff @(posedge clk) begin
        if (beat && rx_sof_i)
            dw0_q <= rx_data_i;
        if (beat && in_tlp && beat_cnt == 2'd1)
            req_dw1_o <= rx_data_i;
        if (beat && in_tlp && beat_cnt == 2'd2) begin
            req_idx_o     <= rx_data_i[4:2];
            req_lo_addr_o <= rx_data_i[6:0];
        end
        if (beat && in_tlp && beat_cnt == 2'd3)
            wr_data_o <= rx_data_i;
    end

    // --------------------------------------------------
    // Register write pulse and completion handshake
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en_o     <= 1'b0;
            compl_req_o <= 1'b0;
        end else begin
            // Zero first byte enable means a zero-length write
            wr_en_o <= beat && in_tlp && beat_cnt == 2'd3 && is_mwr1 &&
                       (req_dw1_o.req.first_be != 4'h0);
            if (beat && in_tlp && beat_cnt == 2'd2 && rx_eof_i && is_mrd1)
                compl_req_o <= 1'b1;
            else if (compl_req_o && compl_ack_i)
                compl_req_o <= 1'b0;
        end
    end

    // Request is held until the TX engine acknowledges it
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        compl_req_o && !compl_ack_i |=> compl_req_o);

    a_sof_framing: assert property (@(posedge clk) disable iff (!rst_n)
        beat && rx_sof_i |-> !in_tlp);

endmodule

`default_nettype wire

// ==== bmd_tx_engine.sv ====
/* Outbound beat sequencer. Sends completions for RX reads and the MWr TLPs
   of the write DMA; a pending completion goes first at each TLP boundary. */
`default_nettype none
`include "bmd_params.svh"

module bmd_tx_engine (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic [`BMD_DW_W-1:0]    tx_data_o,
    output logic                    tx_sof_o,
    output logic                    tx_eof_o,
    output logic                    tx_valid_o,
    input  wire                     tx_ready_i,
    input  wire [15:0]              cfg_completer_id_i,
    input  wire                     cfg_bus_mstr_enable_i,
    input  wire                     init_rst_i,
    input  wire                     compl_req_i,
    output logic                    compl_ack_o,
    input  bmd_pkg::tlp_dw1_u       req_dw1_i,
    input  wire [`BMD_REG_AW-1:0]   req_idx_i,
    input  wire [6:0]               req_lo_addr_i,
    output logic [`BMD_REG_AW-1:0]  rd_idx_o,
    input  wire [`BMD_DW_W-1:0]     rd_data_i,
    input  wire                     dma_start_i,
    input  wire [`BMD_DW_W-1:0]     dma_addr_i,
    input  wire [`BMD_DW_W-1:0]     dma_len_i,
    input  wire [`BMD_DW_W-1:0]     dma_count_i,
    input  wire [`BMD_DW_W-1:0]     dma_pattern_i,
    output logic                    dma_done_o
);
    import bmd_pkg::*;

    logic                 adv;        // Output register may load
    logic                 more;       // Current TLP has beats left
    logic                 tlp_end;
    logic                 start_cpl;
    logic                 nxt_cpl;
    logic [5:0]           nxt_idx;
    logic                 nxt_last;
    logic [`BMD_DW_W-1:0] nxt_word;
    tlp_dw0_t             hdr_dw0;
    tlp_dw1_u             hdr_dw1;
    logic                 is_cpl;
    logic [5:0]           beat_idx;
    logic                 dma_run;
    logic                 dma_take;
    logic [5:0]           len_clamp;
    logic [5:0]           len_q;
    logic [`BMD_DW_W-1:0] addr_q;     // Address of the next DMA TLP
    logic [`BMD_DW_W-1:0] left_q;     // DMA TLPs still to send
    logic [`BMD_DW_W-1:0] pattern_q;

    assign rd_idx_o  = req_idx_i;
    assign adv       = !tx_valid_o || tx_ready_i;
    assign more      = tx_valid_o && !tx_eof_o;
    assign tlp_end   = adv && tx_valid_o && tx_eof_o;
    assign start_cpl = compl_req_i && !compl_ack_o;

    assign nxt_cpl  = more ? is_cpl : start_cpl;
    assign nxt_idx  = more ? beat_idx + 6'd1 : 6'd0;
    assign nxt_last = nxt_cpl ? (nxt_idx == 6'd3) : (nxt_idx == len_q + 6'd2);

    assign len_clamp = (dma_len_i > `BMD_MAX_DMA_LEN) ? 6'(`BMD_MAX_DMA_LEN) :
                       (dma_len_i == '0) ? 6'd1 : dma_len_i[5:0];

    // No new DMA while one runs or a DMA TLP is still on the wire
    assign dma_take = dma_start_i && cfg_bus_mstr_enable_i && !dma_run &&
                      !(tx_valid_o && !is_cpl);

    // --------------------------------------------------
    // Word of the next beat
    // --------------------------------------------------
    always_comb begin
        hdr_dw0          = '0;
        hdr_dw1          = '0;
        hdr_dw0.fmt_type = nxt_cpl ? `BMD_FMT_CPLD : `BMD_FMT_MWR;
        hdr_dw0.length   = nxt_cpl ? 10'd1 : {4'd0, len_q};
        if (nxt_cpl) begin
            hdr_dw1.cpl.completer_id = cfg_completer_id_i;
            hdr_dw1.cpl.byte_count   = 12'd4;
        end else begin
            hdr_dw1.req.requester_id = cfg_completer_id_i;
            hdr_dw1.req.last_be      = 4'hF;
            hdr_dw1.req.first_be     = 4'hF;
        end
        case (nxt_idx)
            6'd0:    nxt_word = hdr_dw0;
            6'd1:    nxt_word = hdr_dw1;
            6'd2:    nxt_word = nxt_cpl ? {req_dw1_i.req.requester_id, req_dw1_i.req.tag,
                                           1'b0, req_lo_addr_i}
                                        : {addr_q[31:2], 2'b00};
            default: nxt_word = nxt_cpl ? rd_data_i : pattern_q;
        endcase
    end

    // --------------------------------------------------
    // Sequencer and handshakes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_valid_o  <= 1'b0;
            tx_sof_o    <= 1'b0;
            tx_eof_o    <= 1'b0;
            is_cpl      <= 1'b0;
            beat_idx    <= 6'd0;
            compl_ack_o <= 1'b0;
            dma_run     <= 1'b0;
            dma_done_o  <= 1'b0;
        end else begin
            dma_done_o <= 1'b0;
            if (compl_ack_o && !compl_req_i)
                compl_ack_o <= 1'b0;
            if (adv) begin
                // Idle cycle after each TLP, then the next one starts
                if (more || (!tx_valid_o && (start_cpl || dma_run))) begin
                    tx_valid_o <= 1'b1;
                    tx_sof_o   <= (nxt_idx == 6'd0);
                    tx_eof_o   <= nxt_last;
                    is_cpl     <= nxt_cpl;
                    beat_idx   <= nxt_idx;
                end else begin
                    tx_valid_o <= 1'b0;
                end
            end
            if (tlp_end && is_cpl)
                compl_ack_o <= 1'b1;
            if (tlp_end && !is_cpl && dma_run && left_q == 'd1) begin
                dma_run    <= 1'b0;
                dma_done_o <= 1'b1;
            end
            if (dma_take) begin
                dma_run    <= (dma_count_i != '0);
                dma_done_o <= (dma_count_i == '0);   // Nothing to send
            end
            if (init_rst_i) begin
                dma_run    <= 1'b0;
                dma_done_o <= 1'b0;
            end
        end
    end

    // Payload and DMA progress
    always_ff @(posedge clk) begin
        if (adv)
            tx_data_o <= nxt_word;
        if (dma_take) begin
            addr_q    <= dma_addr_i;
            len_q     <= len_clamp;
            left_q    <= dma_count_i;
            pattern_q <= dma_pattern_i;
        end else if (tlp_end && !is_cpl) begin
            addr_q <= addr_q + {24'd0, len_q, 2'b00};
            left_q <= left_q - 'd1;
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o) &&
        $stable(tx_sof_o) && $stable(tx_eof_o));

    // Ack only ever follows a live request
    a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        compl_ack_o |-> $past(compl_req_i));

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
bmd_pkg.sv
bmd_rx_engine.sv
bmd_tx_engine.sv
bmd_reg_file.sv
bmd_endpoint.sv
tb_bmd_endpoint.sv

// ==== tb_bmd_endpoint.sv ====
/* Self-checking testbench for the bus-master endpoint. Sends request TLPs
   on the inbound stream and checks every outbound TLP word by word. */
`default_nettype none
`include "bmd_params.svh"

module tb_bmd_endpoint;

    localparam int          TB_SEED        = 86878;
    localparam int          TIMEOUT_CYCLES = 20000;   // Full run needs a few thousand
    localparam logic [15:0] CPL_ID         = 16'h01A0;
    localparam logic [15:0] HOST_ID        = 16'h0008;

    logic        clk;
    logic        rst_n;
    logic [31:0] rx_data_i;
    logic        rx_sof_i;
    logic        rx_eof_i;
    logic        rx_valid_i;
    wire         rx_ready_o;
    wire  [31:0] tx_data_o;
    wire         tx_sof_o;
    wire         tx_eof_o;
    wire         tx_valid_o;
    logic        tx_ready_i;
    logic [15:0] cfg_completer_id_i;
    logic        cfg_bus_mstr_enable_i;

    logic [31:0] lcg_state;
    logic        bp_en;          // Random back-pressure on tx_ready_i
    int          errors;
    int          checks;
    int          cycles;
    logic [7:0]  tag;
    logic [31:0] reg_model [8];
    logic        done_model;
    logic [31:0] cpl_words [$];
    logic        cpl_eofs  [$];
    logic [31:0] dma_words [$];
    logic        dma_eofs  [$];
    logic        mon_in_tlp;
    logic        mon_from_cpl;

    bmd_endpoint dut0 (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .rx_data_i             (rx_data_i),
        .rx_sof_i              (rx_sof_i),
        .rx_eof_i              (rx_eof_i),
        .rx_valid_i            (rx_valid_i),
        .rx_ready_o            (rx_ready_o),
        .tx_data_o             (tx_data_o),
        .tx_sof_o              (tx_sof_o),
        .tx_eof_o              (tx_eof_o),
        .tx_valid_o            (tx_valid_o),
        .tx_ready_i            (tx_ready_i),
        .cfg_completer_id_i    (cfg_completer_id_i),
        .cfg_bus_mstr_enable_i (cfg_bus_mstr_enable_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // --------------------------------------------------
    // Reference TLP builder
    // --------------------------------------------------
    function automatic void expected_tlp(input logic is_cpl, input logic [7:0] req_tag,
                                         input logic [6:0] lo_addr, input logic [31:0] value,
                                         input logic [31:0] base, input logic [31:0] len,
                                         input int tlp_num);
        logic [31:0] clen;
        logic [31:0] addr;
        if (is_cpl) begin
            cpl_words.push_back({1'b0, `BMD_FMT_CPLD, 1'b0, 3'd0, 10'd0, 10'd1});
            cpl_words.push_back({CPL_ID, 3'd0, 1'b0, 12'd4});    // Status 0 and 4 bytes
            cpl_words.push_back({HOST_ID, req_tag, 1'b0, lo_addr});
            cpl_words.push_back(value);
            for (int i = 0; i < 4; i++)
                cpl_eofs.push_back(i == 3);
        end else begin
            clen = (len > `BMD_MAX_DMA_LEN) ? `BMD_MAX_DMA_LEN : len;
            addr = base + 32'd4 * clen * tlp_num;
            dma_words.push_back({1'b0, `BMD_FMT_MWR, 1'b0, 3'd0, 10'd0, clen[9:0]});
            dma_words.push_back({CPL_ID, 8'h00, 4'hF, 4'hF});
            dma_words.push_back({addr[31:2], 2'b00});
            for (int i = 0; i < 3; i++)
                dma_eofs.push_back(1'b0);
            for (int i = 0; i < clen; i++) begin
                dma_words.push_back(value);
                dma_eofs.push_back(i == clen - 1);
            end
        end
    endfunction

    // --------------------------------------------------
    // Inbound stream driver
    // --------------------------------------------------
    task automatic push_beat(input logic [31:0] data, input logic sof, input logic eof);
        logic taken;
        rx_data_i  = data;
        rx_sof_i   = sof;
        rx_eof_i   = eof;
        rx_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rx_ready_o;    // Beat moves on the next edge
            @(posedge clk);
            #10;
        end
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [31:0] data);
        logic [31:0] addr;
        addr = 32'hFE00_0000 | {tag[1:0], idx, 2'b00};
        if (idx >= `BMD_REG_DMA_ADDR && idx <= `BMD_REG_DMA_PATTERN)
            reg_model[idx] = data;
        if (idx == `BMD_REG_CTRL && data[`BMD_CTRL_INIT_RST_BIT])
            done_model = 1'b0;
        if (idx == `BMD_REG_CTRL && data[`BMD_CTRL_START_BIT] && cfg_bus_mstr_enable_i &&
            reg_model[`BMD_REG_DMA_COUNT] != 0) begin
            for (int n = 0; n < reg_model[`BMD_REG_DMA_COUNT]; n++)
                expected_tlp(1'b0, 8'h00, 7'h00, reg_model[`BMD_REG_DMA_PATTERN],
                             reg_model[`BMD_REG_DMA_ADDR], reg_model[`BMD_REG_DMA_LEN], n);
            done_model = 1'b1;
        end
        push_beat({1'b0, `BMD_FMT_MWR, 1'b0, 3'd0, 10'd0, 10'd1}, 1'b1, 1'b0);
        push_beat({HOST_ID, tag, 4'h0, 4'hF}, 1'b0, 1'b0);
        push_beat(addr, 1'b0, 1'b0);
        push_beat(data, 1'b0, 1'b1);
        rx_valid_i = 1'b0;
        tag++;
    endtask

    task automatic read_reg(input logic [2:0] idx);
        logic [31:0] addr;
        logic [31:0] value;
        addr = 32'hFE00_0000 | {tag[1:0], idx, 2'b00};
        if (idx == `BMD_REG_STATUS)
            value = {31'd0, done_model};
        else if (idx >= `BMD_REG_DMA_ADDR && idx <= `BMD_REG_DMA_PATTERN)
            value = reg_model[idx];
        else
            value = 32'd0;    // Control and unmapped
        expected_tlp(1'b1, tag, addr[6:0], value, 32'd0, 32'd0, 0);
        push_beat({1'b0, `BMD_FMT_MRD, 1'b0, 3'd0, 10'd0, 10'd1}, 1'b1, 1'b0);
        push_beat({HOST_ID, tag, 4'h0, 4'hF}, 1'b0, 1'b0);
        push_beat(addr, 1'b0, 1'b1);
        rx_valid_i = 1'b0;
        tag++;
    endtask

    task automatic wait_drained();
        while (cpl_words.size() != 0 || dma_words.size() != 0 || mon_in_tlp) begin
            @(posedge clk);
            #10;
        end
    endtask

    // --------------------------------------------------
    // Outbound monitor and compare
    // --------------------------------------------------
    task automatic compare_beat();
        if (tx_sof_o) begin
            if (mon_in_tlp) begin
                errors++;
                $display("Error: start of a TLP inside another TLP at %0t", $time);
            end
            // Completions may slot in between DMA TLPs
            mon_from_cpl = (cpl_words.size() != 0) && (tx_data_o[30:24] == `BMD_FMT_CPLD);
        end else if (!mon_in_tlp) begin
            errors++;
            $display("Error: outbound beat without start of TLP at %0t", $time);
        end
        if (mon_from_cpl && cpl_words.size() != 0) begin
            check_value("tx_data_o", tx_data_o, cpl_words.pop_front());
            check_value("tx_eof_o", tx_eof_o, cpl_eofs.pop_front());
        end else if (!mon_from_cpl && dma_words.size() != 0) begin
            check_value("tx_data_o", tx_data_o, dma_words.pop_front());
            check_value("tx_eof_o", tx_eof_o, dma_eofs.pop_front());
        end else begin
            errors++;
            $display("Error: outbound beat 0x%08h arrived with no TLP expected", tx_data_o);
        end
        mon_in_tlp = !tx_eof_o;
    endtask

    initial begin
        mon_in_tlp   = 1'b0;
        mon_from_cpl = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && tx_valid_o && tx_ready_i)
                compare_beat();
        end
    end

    initial begin : ready_drive
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            #10;
            if (bp_en) begin
                rnd        = lcg_next();
                tx_ready_i = (rnd[17:16] != 2'b00);    // High about 3 in 4
            end else begin
                tx_ready_i = 1'b1;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : stimulus
        lcg_state  = TB_SEED;
        bp_en      = 1'b0;
        errors     = 0;
        checks     = 0;
        tag        = 8'h10;
        done_model = 1'b0;
        for (int i = 0; i < 8; i++)
            reg_model[i] = 32'd0;
        rst_n                 = 1'b0;
        rx_data_i             = 32'd0;
        rx_sof_i              = 1'b0;
        rx_eof_i              = 1'b0;
        rx_valid_i            = 1'b0;
        tx_ready_i            = 1'b1;
        cfg_completer_id_i    = CPL_ID;
        cfg_bus_mstr_enable_i = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;
        check_value("rx_ready_o", rx_ready_o, 32'd1);
        check_value("tx_valid_o", tx_valid_o, 32'd0);

        // Test 1 covers register write and readback without back-pressure
        for (int idx = 1; idx <= 4; idx++) begin
            write_reg(idx[2:0], lcg_next());
            read_reg(idx[2:0]);
            wait_drained();
        end

        // Test 2 reads control and unmapped indices as zero
        bp_en = 1'b1;
        write_reg(`BMD_REG_CTRL, 32'h0001_0000);    // Start with bus mastering off
        read_reg(`BMD_REG_CTRL);
        read_reg(3'd6);
        read_reg(3'd7);
        wait_drained();

        // Test 3 sends three TLPs of 4 DW
        cfg_bus_mstr_enable_i = 1'b1;
        write_reg(`BMD_REG_DMA_ADDR, 32'h1000_0000);
        write_reg(`BMD_REG_DMA_LEN, 32'd4);
        write_reg(`BMD_REG_DMA_COUNT, 32'd3);
        write_reg(`BMD_REG_DMA_PATTERN, 32'hA5A5_0003);
        write_reg(`BMD_REG_CTRL, 32'h0001_0000);
        wait_drained();
        read_reg(`BMD_REG_STATUS);
        wait_drained();

        // Test 4 clamps length 40 to 32
        write_reg(`BMD_REG_DMA_ADDR, 32'h3000_0100);
        write_reg(`BMD_REG_DMA_LEN, 32'd40);
        write_reg(`BMD_REG_DMA_COUNT, 32'd2);
        write_reg(`BMD_REG_DMA_PATTERN, 32'h5A5A_0040);
        write_reg(`BMD_REG_CTRL, 32'h0001_0000);
        wait_drained();
        read_reg(`BMD_REG_DMA_LEN);
        wait_drained();

        // Test 5 covers init reset and start without bus mastering
        write_reg(`BMD_REG_CTRL, 32'h0000_0001);
        read_reg(`BMD_REG_STATUS);
        cfg_bus_mstr_enable_i = 1'b0;
        write_reg(`BMD_REG_CTRL, 32'h0001_0000);
        repeat (40) @(posedge clk);    // Room for any stray MWr to show up
        #10;
        read_reg(`BMD_REG_STATUS);
        wait_drained();

        // Test 6 reads while a DMA runs under back-pressure
        cfg_bus_mstr_enable_i = 1'b1;
        write_reg(`BMD_REG_DMA_ADDR, 32'h2000_0000);
        write_reg(`BMD_REG_DMA_LEN, 32'd8);
        write_reg(`BMD_REG_DMA_COUNT, 32'd4);
        write_reg(`BMD_REG_DMA_PATTERN, 32'hC3C3_0006);
        write_reg(`BMD_REG_CTRL, 32'h0001_0000);
        read_reg(`BMD_REG_DMA_ADDR);
        read_reg(`BMD_REG_DMA_PATTERN);
        wait_drained();
        read_reg(`BMD_REG_STATUS);
        write_reg(`BMD_REG_CTRL, 32'h0000_0001);
        read_reg(`BMD_REG_STATUS);
        wait_drained();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
